//--- source/lane_pkg.sv
/*
 * Shared widths, value types and encodings of the vector lane:
 * register and bank addressing, immediate, opcodes and compare conditions
 */

package lane_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int data_width = 32;
	localparam int reg_index_width = 4;	// 16 registers over two banks
	localparam int bank_addr_width = reg_index_width - 1;
	localparam int bank_depth = 1 << bank_addr_width;
	localparam int imm_width = 16;
	localparam int shift_width = 5;	// Low bits of source 2 used by shl

	//////////////////////////////////////////////////////////////////////
	// Value types
	//////////////////////////////////////////////////////////////////////

	typedef logic [data_width-1:0] data_t;

	// Bit 0 picks the bank, odd when set
	typedef logic [reg_index_width-1:0] reg_index_t;

	typedef logic [bank_addr_width-1:0] bank_addr_t;

	typedef logic signed [imm_width-1:0] imm_t;

	//////////////////////////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or = 3'd3,
		op_xor = 3'd4,
		op_shl = 3'd5,
		op_load_imm = 3'd6,
		op_compare = 3'd7	// Writes only the mask
	} opcode_t;

	typedef enum logic [1:0] {
		cond_eq = 2'd0,
		cond_ne = 2'd1,
		cond_lt = 2'd2,	// Signed
		cond_ge = 2'd3
	} cond_t;

endpackage

//--- source/lane_register_bank.sv
/*
 * One register bank of the lane, eight words deep,
 * two combinational read ports and one synchronous write port
 */

module lane_register_bank (
	input logic clock,
	input logic reset,
	input logic write_enable,
	input lane_pkg::bank_addr_t write_addr,
	input lane_pkg::data_t write_data,
	input lane_pkg::bank_addr_t read_addr_a,
	input lane_pkg::bank_addr_t read_addr_b,
	output lane_pkg::data_t read_data_a,
	output lane_pkg::data_t read_data_b
);

	lane_pkg::data_t regs [lane_pkg::bank_depth];

	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end
		else if (write_enable) begin
			regs[write_addr] <= write_data;
		end
	end

	// Old value on a same-cycle write, forwarding covers it
	assign read_data_a = regs[read_addr_a];
	assign read_data_b = regs[read_addr_b];

endmodule

//--- source/lane_operand_read.sv
/*
 * Command capture, bank read routing, operand selection with
 * forwarding from execute and result stages, and the operand register
 */

module lane_operand_read (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic command_valid,
	input lane_pkg::opcode_t opcode,
	input lane_pkg::cond_t cond,
	input logic masked,
	input lane_pkg::reg_index_t dst,
	input lane_pkg::reg_index_t src1,
	input lane_pkg::reg_index_t src2,
	input lane_pkg::imm_t immediate,
	output lane_pkg::bank_addr_t even_read_addr_a,
	output lane_pkg::bank_addr_t even_read_addr_b,
	output lane_pkg::bank_addr_t odd_read_addr_a,
	output lane_pkg::bank_addr_t odd_read_addr_b,
	input lane_pkg::data_t even_data_a,
	input lane_pkg::data_t even_data_b,
	input lane_pkg::data_t odd_data_a,
	input lane_pkg::data_t odd_data_b,
	input logic exec_fwd_write,
	input lane_pkg::reg_index_t exec_fwd_index,
	input lane_pkg::data_t exec_fwd_data,
	input logic result_write,
	input lane_pkg::reg_index_t result_fwd_index,
	input lane_pkg::data_t result_fwd_data,
	output logic operand_valid,
	output lane_pkg::opcode_t operand_opcode,
	output lane_pkg::cond_t operand_cond,
	output logic operand_masked,
	output lane_pkg::reg_index_t operand_dst,
	output lane_pkg::data_t operand_a,
	output lane_pkg::data_t operand_b
);

	logic cap_valid;
	lane_pkg::opcode_t cap_opcode;
	lane_pkg::cond_t cap_cond;
	logic cap_masked;
	lane_pkg::reg_index_t cap_dst;
	lane_pkg::reg_index_t cap_src1;
	lane_pkg::reg_index_t cap_src2;
	lane_pkg::imm_t cap_immediate;

	lane_pkg::data_t bank_a;
	lane_pkg::data_t bank_b;
	lane_pkg::data_t src1_data;
	lane_pkg::data_t src2_data;
	lane_pkg::data_t imm_extended;

	//////////////////////////////////////////////////////////////////////
	// Capture stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			cap_valid <= 1'b0;
			cap_opcode <= lane_pkg::op_add;
			cap_cond <= lane_pkg::cond_eq;
			cap_masked <= 1'b0;
			cap_dst <= '0;
			cap_src1 <= '0;
			cap_src2 <= '0;
			cap_immediate <= '0;
		end
		else if (enable) begin
			cap_valid <= command_valid;
			cap_opcode <= opcode;
			cap_cond <= cond;
			cap_masked <= masked;
			cap_dst <= dst;
			cap_src1 <= src1;
			cap_src2 <= src2;
			cap_immediate <= immediate;
		end
	end

	// Source 1 on port a, source 2 on port b of both banks
	assign even_read_addr_a = cap_src1[lane_pkg::reg_index_width-1:1];
	assign odd_read_addr_a = cap_src1[lane_pkg::reg_index_width-1:1];
	assign even_read_addr_b = cap_src2[lane_pkg::reg_index_width-1:1];
	assign odd_read_addr_b = cap_src2[lane_pkg::reg_index_width-1:1];

	assign bank_a = cap_src1[0] ? odd_data_a : even_data_a;
	assign bank_b = cap_src2[0] ? odd_data_b : even_data_b;

	// Youngest producer first
	assign src1_data = (exec_fwd_write && exec_fwd_index == cap_src1) ? exec_fwd_data :
		(result_write && result_fwd_index == cap_src1) ? result_fwd_data : bank_a;
	assign src2_data = (exec_fwd_write && exec_fwd_index == cap_src2) ? exec_fwd_data :
		(result_write && result_fwd_index == cap_src2) ? result_fwd_data : bank_b;

	assign imm_extended = {{(lane_pkg::data_width - lane_pkg::imm_width){
		cap_immediate[lane_pkg::imm_width-1]}}, cap_immediate};

	//////////////////////////////////////////////////////////////////////
	// Operand register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			operand_valid <= 1'b0;
			operand_opcode <= lane_pkg::op_add;
			operand_cond <= lane_pkg::cond_eq;
			operand_masked <= 1'b0;
			operand_dst <= '0;
			operand_a <= '0;
			operand_b <= '0;
		end
		else if (enable) begin
			operand_valid <= cap_valid;
			operand_opcode <= cap_opcode;
			operand_cond <= cap_cond;
			operand_masked <= cap_masked;
			operand_dst <= cap_dst;
			operand_a <= src1_data;
			operand_b <= (cap_opcode == lane_pkg::op_load_imm) ? imm_extended : src2_data;
		end
	end

endmodule

//--- source/lane_mask_unit.sv
/*
 * Signed compare conditions and the lane mask register
 */

module lane_mask_unit (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic update,
	input lane_pkg::cond_t cond,
	input lane_pkg::data_t operand_a,
	input lane_pkg::data_t operand_b,
	output logic mask
);

	logic signed [lane_pkg::data_width-1:0] a_signed;
	logic signed [lane_pkg::data_width-1:0] b_signed;
	logic cond_true;

	assign a_signed = operand_a;
	assign b_signed = operand_b;

	always_comb begin
		case (cond)
			lane_pkg::cond_eq: cond_true = (a_signed == b_signed);
			lane_pkg::cond_ne: cond_true = (a_signed != b_signed);
			lane_pkg::cond_lt: cond_true = (a_signed < b_signed);
			lane_pkg::cond_ge: cond_true = (a_signed >= b_signed);
			default: cond_true = 1'b1;
		endcase
	end

	// All lanes active out of reset
	always_ff @(posedge clock) begin
		if (reset) begin
			mask <= 1'b1;
		end
		else if (update && enable) begin
			mask <= cond_true;
		end
	end

endmodule

//--- source/lane_exec_unit.sv
/*
 * Arithmetic unit, write decision under the mask, and the result
 * register that feeds forwarding and the bank write port
 */

module lane_exec_unit (
	input logic clock,
	input logic reset,
	input logic enable,
	input logic operand_valid,
	input lane_pkg::opcode_t operand_opcode,
	input lane_pkg::cond_t operand_cond,
	input logic operand_masked,
	input lane_pkg::reg_index_t operand_dst,
	input lane_pkg::data_t operand_a,
	input lane_pkg::data_t operand_b,
	output logic exec_fwd_write,
	output lane_pkg::reg_index_t exec_fwd_index,
	output lane_pkg::data_t exec_fwd_data,
	output logic result_valid,
	output lane_pkg::reg_index_t result_index,
	output lane_pkg::data_t result_data,
	output logic even_write_enable,
	output logic odd_write_enable,
	output lane_pkg::bank_addr_t write_addr,
	output logic mask
);

	lane_pkg::data_t alu_result;
	logic is_compare;
	logic result_write;

	//////////////////////////////////////////////////////////////////////
	// Arithmetic
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (operand_opcode)
			lane_pkg::op_add: alu_result = operand_a + operand_b;
			lane_pkg::op_sub: alu_result = operand_a - operand_b;
			lane_pkg::op_and: alu_result = operand_a & operand_b;
			lane_pkg::op_or: alu_result = operand_a | operand_b;
			lane_pkg::op_xor: alu_result = operand_a ^ operand_b;
			lane_pkg::op_shl: alu_result = operand_a << operand_b[lane_pkg::shift_width-1:0];
			lane_pkg::op_load_imm: alu_result = operand_b;	// Extended upstream
			default: alu_result = '0;
		endcase
	end

	assign is_compare = (operand_opcode == lane_pkg::op_compare);

	lane_mask_unit mask_unit (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.update(operand_valid & is_compare),
		.cond(operand_cond),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.mask(mask)
	);

	// Masked commands drop out while the mask is low
	assign exec_fwd_write = operand_valid && !is_compare && !(operand_masked && !mask);
	assign exec_fwd_index = operand_dst;
	assign exec_fwd_data = alu_result;

	//////////////////////////////////////////////////////////////////////
	// Result register and write-back
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			result_write <= 1'b0;
			result_index <= '0;
			result_data <= '0;
		end
		else if (enable) begin
			result_write <= exec_fwd_write;
			result_index <= operand_dst;
			result_data <= alu_result;
		end
	end

	assign result_valid = result_write & enable;
	assign even_write_enable = result_valid & ~result_index[0];
	assign odd_write_enable = result_valid & result_index[0];
	assign write_addr = result_index[lane_pkg::reg_index_width-1:1];

endmodule

//--- source/lane_unit.sv
/*
 * Top level of the lane: even and odd register banks,
 * operand read stage and execution stage
 */

module lane_unit (
	input logic clock,
	input logic reset,
	input logic command_valid,
	input lane_pkg::opcode_t opcode,
	input lane_pkg::cond_t cond,
	input logic masked,
	input lane_pkg::reg_index_t dst,
	input lane_pkg::reg_index_t src1,
	input lane_pkg::reg_index_t src2,
	input lane_pkg::imm_t immediate,
	input logic enable,
	output logic result_valid,
	output lane_pkg::reg_index_t result_index,
	output lane_pkg::data_t result_data,
	output logic mask
);

	lane_pkg::bank_addr_t even_read_addr_a;
	lane_pkg::bank_addr_t even_read_addr_b;
	lane_pkg::bank_addr_t odd_read_addr_a;
	lane_pkg::bank_addr_t odd_read_addr_b;
	lane_pkg::data_t even_data_a;
	lane_pkg::data_t even_data_b;
	lane_pkg::data_t odd_data_a;
	lane_pkg::data_t odd_data_b;

	logic exec_fwd_write;
	lane_pkg::reg_index_t exec_fwd_index;
	lane_pkg::data_t exec_fwd_data;

	logic operand_valid;
	lane_pkg::opcode_t operand_opcode;
	lane_pkg::cond_t operand_cond;
	logic operand_masked;
	lane_pkg::reg_index_t operand_dst;
	lane_pkg::data_t operand_a;
	lane_pkg::data_t operand_b;

	logic even_write_enable;
	logic odd_write_enable;
	lane_pkg::bank_addr_t write_addr;

	lane_register_bank bank_even (
		.clock(clock),
		.reset(reset),
		.write_enable(even_write_enable),
		.write_addr(write_addr),
		.write_data(result_data),
		.read_addr_a(even_read_addr_a),
		.read_addr_b(even_read_addr_b),
		.read_data_a(even_data_a),
		.read_data_b(even_data_b)
	);

	lane_register_bank bank_odd (
		.clock(clock),
		.reset(reset),
		.write_enable(odd_write_enable),
		.write_addr(write_addr),
		.write_data(result_data),
		.read_addr_a(odd_read_addr_a),
		.read_addr_b(odd_read_addr_b),
		.read_data_a(odd_data_a),
		.read_data_b(odd_data_b)
	);

	lane_operand_read operand_read (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.command_valid(command_valid),
		.opcode(opcode),
		.cond(cond),
		.masked(masked),
		.dst(dst),
		.src1(src1),
		.src2(src2),
		.immediate(immediate),
		.even_read_addr_a(even_read_addr_a),
		.even_read_addr_b(even_read_addr_b),
		.odd_read_addr_a(odd_read_addr_a),
		.odd_read_addr_b(odd_read_addr_b),
		.even_data_a(even_data_a),
		.even_data_b(even_data_b),
		.odd_data_a(odd_data_a),
		.odd_data_b(odd_data_b),
		.exec_fwd_write(exec_fwd_write),
		.exec_fwd_index(exec_fwd_index),
		.exec_fwd_data(exec_fwd_data),
		.result_write(result_valid),	// Write flag, qualified by enable
		.result_fwd_index(result_index),
		.result_fwd_data(result_data),
		.operand_valid(operand_valid),
		.operand_opcode(operand_opcode),
		.operand_cond(operand_cond),
		.operand_masked(operand_masked),
		.operand_dst(operand_dst),
		.operand_a(operand_a),
		.operand_b(operand_b)
	);

	lane_exec_unit exec_unit (
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.operand_valid(operand_valid),
		.operand_opcode(operand_opcode),
		.operand_cond(operand_cond),
		.operand_masked(operand_masked),
		.operand_dst(operand_dst),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.exec_fwd_write(exec_fwd_write),
		.exec_fwd_index(exec_fwd_index),
		.exec_fwd_data(exec_fwd_data),
		.result_valid(result_valid),
		.result_index(result_index),
		.result_data(result_data),
		.even_write_enable(even_write_enable),
		.odd_write_enable(odd_write_enable),
		.write_addr(write_addr),
		.mask(mask)
	);

endmodule

//--- testbench/lane_unit_tb.sv
/*
 * Testbench for the lane with clock and reset, seeded random commands,
 * an in-order reference model with result and mask checks, and a watchdog
 */

module lane_unit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int test1_cycles = 16;
	localparam int test2_cycles = 500;
	localparam int test4_cycles = 300;
	localparam int test5_cycles = 400;
	localparam int drain_limit = 8;
	localparam int total_cycles = 10 + test1_cycles + test2_cycles + test4_cycles
		+ test5_cycles + 4 * drain_limit;

	logic clock;
	logic reset;
	logic command_valid;
	lane_pkg::opcode_t opcode;
	lane_pkg::cond_t cond;
	logic masked;
	lane_pkg::reg_index_t dst;
	lane_pkg::reg_index_t src1;
	lane_pkg::reg_index_t src2;
	lane_pkg::imm_t immediate;
	logic enable;
	logic result_valid;
	lane_pkg::reg_index_t result_index;
	lane_pkg::data_t result_data;
	logic mask;

	lane_pkg::data_t model_regs [16];
	logic model_mask;
	logic expected_mask;
	lane_pkg::reg_index_t exp_index_q [$];
	lane_pkg::data_t exp_data_q [$];
	int exp_tag_q [$];
	int mask_tag_q [$];
	logic mask_value_q [$];
	int pipe_count;	// Enabled edges since reset
	int errors;
	int checks;

	lane_unit UUT (
		.clock(clock),
		.reset(reset),
		.command_valid(command_valid),
		.opcode(opcode),
		.cond(cond),
		.masked(masked),
		.dst(dst),
		.src1(src1),
		.src2(src2),
		.immediate(immediate),
		.enable(enable),
		.result_valid(result_valid),
		.result_index(result_index),
		.result_data(result_data),
		.mask(mask)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		#(total_cycles * 20 + 2000);
		$display("timeout, the run did not finish in time");
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic lane_pkg::data_t model_result(input lane_pkg::opcode_t op,
		input lane_pkg::data_t a, input lane_pkg::data_t b, input lane_pkg::imm_t imm);
		case (op)
			lane_pkg::op_add: return a + b;
			lane_pkg::op_sub: return a - b;
			lane_pkg::op_and: return a & b;
			lane_pkg::op_or: return a | b;
			lane_pkg::op_xor: return a ^ b;
			lane_pkg::op_shl: return a << b[4:0];
			lane_pkg::op_load_imm: return {{16{imm[15]}}, imm};
			default: return '0;
		endcase
	endfunction

	function automatic logic model_condition(input lane_pkg::cond_t cd,
		input lane_pkg::data_t a, input lane_pkg::data_t b);
		case (cd)
			lane_pkg::cond_eq: return a == b;
			lane_pkg::cond_ne: return a != b;
			lane_pkg::cond_lt: return $signed(a) < $signed(b);
			default: return $signed(a) >= $signed(b);
		endcase
	endfunction

	// Mostly a small pool so dependencies are frequent
	function automatic lane_pkg::reg_index_t random_index();
		if ($urandom_range(3) == 0)
			return 4'($urandom);
		return 4'($urandom_range(0, 4));
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, expected);
		errors++;
	endtask

	task automatic check_outputs();
		lane_pkg::reg_index_t want_index;
		lane_pkg::data_t want_data;
		int want_tag;
		while (mask_tag_q.size() > 0 && mask_tag_q[0] + 2 <= pipe_count) begin
			expected_mask = mask_value_q.pop_front();
			void'(mask_tag_q.pop_front());
		end
		checks++;
		if (mask !== expected_mask)
			report_mismatch("mask", 32'(mask), 32'(expected_mask));
		if (!enable && result_valid) begin
			$display("result_valid is high at %0t while enable is low", $time);
			errors++;
		end
		if (result_valid) begin
			if (exp_tag_q.size() == 0) begin
				$display("result_valid is high at %0t with no result expected", $time);
				errors++;
			end
			else begin
				want_index = exp_index_q.pop_front();
				want_data = exp_data_q.pop_front();
				want_tag = exp_tag_q.pop_front();
				checks += 3;
				if (result_index !== want_index)
					report_mismatch("result_index", 32'(result_index), 32'(want_index));
				if (result_data !== want_data)
					report_mismatch("result_data", result_data, want_data);
				if (pipe_count != want_tag + 2)	// Two edges after acceptance
					report_mismatch("result cycle", pipe_count, want_tag + 2);
			end
		end
	endtask

	task automatic run_cycle();
		@(negedge clock);
		check_outputs();
		@(posedge clock);
		if (enable)
			pipe_count++;
		#2;
	endtask

	task automatic issue(input logic valid, input lane_pkg::opcode_t op,
		input lane_pkg::cond_t cd, input logic msk, input lane_pkg::reg_index_t d,
		input lane_pkg::reg_index_t s1, input lane_pkg::reg_index_t s2,
		input lane_pkg::imm_t imm, input logic en);
		lane_pkg::data_t a;
		lane_pkg::data_t b;
		command_valid = valid;
		opcode = op;
		cond = cd;
		masked = msk;
		dst = d;
		src1 = s1;
		src2 = s2;
		immediate = imm;
		enable = en;
		if (valid && en) begin
			a = model_regs[s1];
			b = model_regs[s2];
			if (op == lane_pkg::op_compare) begin
				model_mask = model_condition(cd, a, b);
				mask_tag_q.push_back(pipe_count + 1);
				mask_value_q.push_back(model_mask);
			end
			else if (!(msk && !model_mask)) begin
				model_regs[d] = model_result(op, a, b, imm);
				exp_index_q.push_back(d);
				exp_data_q.push_back(model_regs[d]);
				exp_tag_q.push_back(pipe_count + 1);
			end
		end
		run_cycle();
	endtask

	task automatic issue_random(input int compare_pct, input int masked_pct,
		input logic valid, input logic en);
		lane_pkg::opcode_t op;
		lane_pkg::imm_t imm;
		if (int'($urandom_range(99)) < compare_pct)
			op = lane_pkg::op_compare;
		else
			op = lane_pkg::opcode_t'(3'($urandom_range(0, 6)));
		if ($urandom_range(1) == 0)
			imm = 16'($urandom_range(0, 3));	// Small values make equal compares likely
		else
			imm = 16'($urandom);
		issue(valid, op, lane_pkg::cond_t'(2'($urandom)),
			int'($urandom_range(99)) < masked_pct,
			random_index(), random_index(), random_index(), imm, en);
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		while ((exp_tag_q.size() > 0 || mask_tag_q.size() > 0) && waited < drain_limit) begin
			issue(1'b0, lane_pkg::op_add, lane_pkg::cond_eq, 1'b0, '0, '0, '0, '0, 1'b1);
			waited++;
		end
		if (exp_tag_q.size() > 0 || mask_tag_q.size() > 0) begin
			$display("expected results or mask updates did not appear at %0t", $time);
			errors++;
		end
	endtask

	task automatic print_test_summary(input string name, input int errors_before);
		$display("%-36s done, %0d errors", name, errors - errors_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int errors_before;
		int stall_left;
		logic en;
		void'($urandom(69));
		reset = 1'b1;
		command_valid = 1'b0;
		opcode = lane_pkg::op_add;
		cond = lane_pkg::cond_eq;
		masked = 1'b0;
		dst = '0;
		src1 = '0;
		src2 = '0;
		immediate = '0;
		enable = 1'b1;
		foreach (model_regs[i])
			model_regs[i] = '0;
		model_mask = 1'b1;
		expected_mask = 1'b1;
		pipe_count = 0;
		errors = 0;
		checks = 0;
		stall_left = 0;
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;

		// Reset values and every register doubled stays zero
		errors_before = errors;
		checks += 2;
		if (result_valid !== 1'b0)
			report_mismatch("result_valid", 32'(result_valid), 32'd0);
		if (mask !== 1'b1)
			report_mismatch("mask", 32'(mask), 32'd1);
		for (int i = 0; i < test1_cycles; i++)
			issue(1'b1, lane_pkg::op_add, lane_pkg::cond_eq, 1'b0, 4'(i), 4'(i), 4'(i),
				'0, 1'b1);
		drain_pipeline();
		print_test_summary("reset state", errors_before);

		errors_before = errors;
		for (int i = 0; i < test2_cycles; i++)
			issue_random(12, 10, 1'b1, 1'b1);
		drain_pipeline();
		print_test_summary("random back to back with timing", errors_before);

		errors_before = errors;
		for (int i = 0; i < test4_cycles; i++)
			issue_random(35, 60, 1'b1, 1'b1);
		drain_pipeline();
		print_test_summary("compares and masked commands", errors_before);

		// Stretches of low enable with commands still presented
		errors_before = errors;
		for (int i = 0; i < test5_cycles; i++) begin
			if (stall_left > 0) begin
				en = 1'b0;
				stall_left--;
			end
			else if ($urandom_range(9) == 0) begin
				en = 1'b0;
				stall_left = int'($urandom_range(1, 5));
			end
			else
				en = 1'b1;
			issue_random(15, 40, $urandom_range(3) != 0, en);
		end
		drain_pipeline();
		print_test_summary("enable stalls", errors_before);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- all.f
source/lane_pkg.sv
source/lane_register_bank.sv
source/lane_operand_read.sv
source/lane_mask_unit.sv
source/lane_exec_unit.sv
source/lane_unit.sv
testbench/lane_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build the lane testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f all.f --top-module lane_unit_tb -o lane_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/lane_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "all tests passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
